// File: logic/video_bus_pkg.sv
package video_bus_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Bus widths
    ////////////////////////////////////////////////////////////////////////////
    localparam int REG_ADDR_W   = 19;
    localparam int MEM_ADDR_W   = 18;
    localparam int FETCH_ADDR_W = 16;
    localparam int RAM_IDX_W    = 15;
    localparam int ATTR_IDX_W   = 8;
    localparam int ATTR_DEPTH   = 256;
    localparam int FETCH_PORTS  = 2;

    ////////////////////////////////////////////////////////////////////////////
    // Register bus memory map
    ////////////////////////////////////////////////////////////////////////////
    // Main RAM sits at 00000-1FFFF, everything below bit RAM_IDX_W+2
    localparam logic [REG_ADDR_W-1:0] PAL_BASE = 19'h40200;
    localparam int PAL_MASK_BITS = 9;
    localparam logic [REG_ADDR_W-1:0] SPR_BASE = 19'h40800;
    localparam int SPR_MASK_BITS = 11;

    ////////////////////////////////////////////////////////////////////////////
    // Grouped signals
    ////////////////////////////////////////////////////////////////////////////
    typedef struct packed {
        logic [REG_ADDR_W-1:0] addr;
        logic [7:0]            wrdata;
        logic                  strobe;
        logic                  write;
    } regbus_req_t;

    // One layer-fetch master, word addressed
    typedef struct packed {
        logic [FETCH_ADDR_W-1:0] addr;
        logic                    strobe;
    } fetch_req_t;

    typedef struct packed {
        logic [RAM_IDX_W-1:0] idx;
        logic [1:0]           lane;
        logic [7:0]           wrbyte;
        logic                 we;
    } ram_port_t;

    typedef struct packed {
        logic [3:0] rsvd;
        logic [3:0] red;
        logic [3:0] green;
        logic [3:0] blue;
    } palette_entry_t;

    typedef logic [31:0] sprite_attr_t;

    typedef enum logic [1:0] {
        REGION_NONE,
        REGION_MAIN,
        REGION_PAL,
        REGION_SPR
    } region_t;

endpackage

// File: logic/main_ram.sv
`timescale 1ns/1ps

module main_ram
    import video_bus_pkg::*;
(
    input  logic        clk,
    input  ram_port_t   port_i,
    output logic [31:0] rddata_o
);

    // 32K words, four byte lanes each
    logic [3:0][7:0] mem [(1 << RAM_IDX_W)];
    logic [3:0]      byte_en;

    // One-hot lane select, only while writing
    always_comb begin
        byte_en = '0;
        if (port_i.we) begin
            byte_en[port_i.lane] = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < 4; i++) begin
            if (byte_en[i]) begin
                mem[port_i.idx][i] <= port_i.wrbyte;
            end
        end
    end

    // Read old data on a same-cycle write
    always_ff @(posedge clk) begin
        rddata_o <= mem[port_i.idx];
    end

endmodule

// File: logic/attr_ram.sv
`timescale 1ns/1ps

module attr_ram
    import video_bus_pkg::*;
#(
    parameter type word_t = palette_entry_t
)(
    input  logic                                 clk,

    // Host write and read-back
    input  logic                                 we_i,
    input  logic [ATTR_IDX_W-1:0]                wr_idx_i,
    input  logic [$clog2($bits(word_t) / 8)-1:0] lane_i,
    input  logic [7:0]                           wr_byte_i,
    output logic [7:0]                           rdbyte_o,

    // Display lookup
    input  logic [ATTR_IDX_W-1:0]                look_idx_i,
    output word_t                                look_o
);

    localparam int LANES = $bits(word_t) / 8;

    logic [LANES-1:0][7:0] mem [ATTR_DEPTH];

    logic [LANES-1:0][7:0] rb_word_r;
    logic [$clog2(LANES)-1:0] rb_lane_r;

    // Single byte writes into the chosen lane
    always_ff @(posedge clk) begin
        if (we_i) begin
            mem[wr_idx_i][lane_i] <= wr_byte_i;
        end
    end

    // Display side port
    always_ff @(posedge clk) begin
        look_o <= word_t'(mem[look_idx_i]);
    end

    // Host side port, lane picked after the word is out
    always_ff @(posedge clk) begin
        rb_word_r <= mem[wr_idx_i];
        rb_lane_r <= lane_i;
    end

    assign rdbyte_o = rb_word_r[rb_lane_r];

endmodule

// File: logic/bus_control.sv
`timescale 1ns/1ps

module bus_control
    import video_bus_pkg::*;
(
    input  logic                         clk,
    input  logic                         reset,

    // Host register bus
    input  regbus_req_t                  host_req_i,
    output logic [7:0]                   host_rddata_o,

    // Layer fetch masters
    input  fetch_req_t [FETCH_PORTS-1:0] fetch_req_i,
    output logic [FETCH_PORTS-1:0]       fetch_ack_o,
    output logic [31:0]                  fetch_rddata_o,

    // Main RAM port
    output ram_port_t                    ram_o,
    input  logic [31:0]                  ram_rddata_i,

    // Attribute memories
    output logic                         pal_we_o,
    output logic                         spr_we_o,
    input  logic [7:0]                   pal_rdbyte_i,
    input  logic [7:0]                   spr_rdbyte_i
);

    logic                   main_hit;
    logic                   pal_hit;
    logic                   spr_hit;
    region_t                host_region;
    logic                   host_wr;
    logic                   host_ram_req;

    logic [MEM_ADDR_W-1:0]  mem_addr;
    logic                   mem_write;
    logic [FETCH_PORTS-1:0] grant;

    logic [FETCH_PORTS-1:0] grant_r;
    logic                   fetch_in_ram_r;
    region_t                region_r;
    logic [1:0]             lane_r;

    ////////////////////////////////////////////////////////////////////////////
    // Address decode
    ////////////////////////////////////////////////////////////////////////////
    assign main_hit = host_req_i.addr[REG_ADDR_W-1:RAM_IDX_W+2] == '0;
    assign pal_hit  = host_req_i.addr[REG_ADDR_W-1:PAL_MASK_BITS]
                      == PAL_BASE[REG_ADDR_W-1:PAL_MASK_BITS];
    assign spr_hit  = host_req_i.addr[REG_ADDR_W-1:SPR_MASK_BITS]
                      == SPR_BASE[REG_ADDR_W-1:SPR_MASK_BITS];

    always_comb begin
        host_region = REGION_NONE;
        if (main_hit) begin
            host_region = REGION_MAIN;
        end else if (pal_hit) begin
            host_region = REGION_PAL;
        end else if (spr_hit) begin
            host_region = REGION_SPR;
        end
    end

    assign host_wr      = host_req_i.strobe && host_req_i.write;
    assign host_ram_req = host_req_i.strobe && (host_region == REGION_MAIN);
    assign pal_we_o     = host_wr && (host_region == REGION_PAL);
    assign spr_we_o     = host_wr && (host_region == REGION_SPR);

    ////////////////////////////////////////////////////////////////////////////
    // Main RAM arbitration
    ////////////////////////////////////////////////////////////////////////////
    // Host first, then fetch port 0, then port 1; the host never waits
    always_comb begin
        mem_addr  = '0;
        mem_write = 1'b0;
        grant     = '0;
        if (host_ram_req) begin
            mem_addr  = host_req_i.addr[MEM_ADDR_W-1:0];
            mem_write = host_req_i.write;
        end else begin
            // Walk down so the lowest strobing port wins
            for (int i = FETCH_PORTS - 1; i >= 0; i--) begin
                if (fetch_req_i[i].strobe) begin
                    grant    = '0;
                    grant[i] = 1'b1;
                    mem_addr = {fetch_req_i[i].addr, 2'b00};
                end
            end
        end
    end

    // Byte lane and word index straight from the byte address
    assign ram_o.idx    = mem_addr[RAM_IDX_W+1:2];
    assign ram_o.lane   = mem_addr[1:0];
    assign ram_o.wrbyte = host_req_i.wrdata;
    assign ram_o.we     = mem_write;

    ////////////////////////////////////////////////////////////////////////////
    // Response pipeline
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            grant_r        <= '0;
            fetch_in_ram_r <= 1'b0;
            region_r       <= REGION_NONE;
        end else begin
            grant_r        <= grant;
            // Upper half of the fetch space has no RAM behind it
            fetch_in_ram_r <= ~mem_addr[MEM_ADDR_W-1];
            if (host_req_i.strobe && !host_req_i.write) begin
                region_r <= host_region;
            end else begin
                region_r <= REGION_NONE;
            end
        end
    end

    always_ff @(posedge clk) begin
        lane_r <= host_req_i.addr[1:0];
    end

    assign fetch_ack_o    = grant_r;
    assign fetch_rddata_o = fetch_in_ram_r ? ram_rddata_i : '0;

    // Host read data, valid only in the cycle after a read strobe
    always_comb begin
        case (region_r)
            REGION_MAIN: host_rddata_o = ram_rddata_i[{lane_r, 3'b000} +: 8];
            REGION_PAL:  host_rddata_o = pal_rdbyte_i;
            REGION_SPR:  host_rddata_o = spr_rdbyte_i;
            default:     host_rddata_o = '0;
        endcase
    end

endmodule

// File: logic/video_bus_top.sv
`timescale 1ns/1ps

module video_bus_top
    import video_bus_pkg::*;
(
    input  logic                         clk,
    input  logic                         reset,

    // Host register bus
    input  regbus_req_t                  host_req_i,
    output logic [7:0]                   host_rddata_o,

    // Layer fetch masters
    input  fetch_req_t [FETCH_PORTS-1:0] fetch_req_i,
    output logic [FETCH_PORTS-1:0]       fetch_ack_o,
    output logic [31:0]                  fetch_rddata_o,

    // Display lookups
    input  logic [7:0]                   pixel_i,
    output logic [11:0]                  rgb_o,
    input  logic [ATTR_IDX_W-1:0]        sprite_idx_i,
    output sprite_attr_t                 sprite_attr_o
);

    ram_port_t      ram_port;
    logic [31:0]    ram_rddata;
    logic           pal_we;
    logic           spr_we;
    logic [7:0]     pal_rdbyte;
    logic [7:0]     spr_rdbyte;
    palette_entry_t pal_entry;

    bus_control bus_control_inst (
        .clk            (clk),
        .reset          (reset),
        .host_req_i     (host_req_i),
        .fetch_req_i    (fetch_req_i),
        .fetch_ack_o    (fetch_ack_o),
        .fetch_rddata_o (fetch_rddata_o),
        .host_rddata_o  (host_rddata_o),
        .ram_o          (ram_port),
        .ram_rddata_i   (ram_rddata),
        .pal_we_o       (pal_we),
        .spr_we_o       (spr_we),
        .pal_rdbyte_i   (pal_rdbyte),
        .spr_rdbyte_i   (spr_rdbyte)
    );

    main_ram main_ram_inst (
        .clk      (clk),
        .port_i   (ram_port),
        .rddata_o (ram_rddata)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Palette, two bytes per entry
    ////////////////////////////////////////////////////////////////////////////
    attr_ram #(.word_t(palette_entry_t)) palette_ram (
        .clk        (clk),
        .we_i       (pal_we),
        .wr_idx_i   (host_req_i.addr[8:1]),
        .lane_i     (host_req_i.addr[0]),
        .wr_byte_i  (host_req_i.wrdata),
        .rdbyte_o   (pal_rdbyte),
        .look_idx_i (pixel_i),
        .look_o     (pal_entry)
    );

    assign rgb_o = {pal_entry.red, pal_entry.green, pal_entry.blue};

    ////////////////////////////////////////////////////////////////////////////
    // Sprite attributes, four bytes per entry
    ////////////////////////////////////////////////////////////////////////////
    attr_ram #(.word_t(sprite_attr_t)) sprite_attr_ram (
        .clk        (clk),
        .we_i       (spr_we),
        .wr_idx_i   (host_req_i.addr[9:2]),
        .lane_i     (host_req_i.addr[1:0]),
        .wr_byte_i  (host_req_i.wrdata),
        .rdbyte_o   (spr_rdbyte),
        .look_idx_i (sprite_idx_i),
        .look_o     (sprite_attr_o)
    );

endmodule

// File: test/video_bus_tb.sv
`timescale 1ns/1ps

module video_bus_tb
    import video_bus_pkg::*;
();

    typedef enum logic [2:0] {
        OP_WRITE,
        OP_READ,
        OP_FETCH,
        OP_ARB,
        OP_PIXEL,
        OP_SPRITE
    } op_t;

    typedef struct packed {
        op_t                   op;
        logic [REG_ADDR_W-1:0] addr;
        logic [7:0]            data;
        logic [31:0]           exp_val;
    } step_t;

    logic                         clk;
    logic                         reset;
    regbus_req_t                  host_req;
    logic [7:0]                   host_rddata;
    fetch_req_t [FETCH_PORTS-1:0] fetch_req;
    logic [FETCH_PORTS-1:0]       fetch_ack;
    logic [31:0]                  fetch_rddata;
    logic [7:0]                   pixel;
    logic [11:0]                  rgb;
    logic [ATTR_IDX_W-1:0]        sprite_idx;
    sprite_attr_t                 sprite_attr;

    logic [15:0] lfsr_state = 16'd34;
    logic [7:0]  sb [int];
    step_t       steps [$];
    int          cycle_count = 0;
    int          timeout_limit = 0;

    video_bus_top video_bus_top_inst (
        .clk            (clk),
        .reset          (reset),
        .host_req_i     (host_req),
        .host_rddata_o  (host_rddata),
        .fetch_req_i    (fetch_req),
        .fetch_ack_o    (fetch_ack),
        .fetch_rddata_o (fetch_rddata),
        .pixel_i        (pixel),
        .rgb_o          (rgb),
        .sprite_idx_i   (sprite_idx),
        .sprite_attr_o  (sprite_attr)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (timeout_limit > 0 && cycle_count >= timeout_limit) begin
            $display("Timeout: the run did not finish within %0d cycles", timeout_limit);
            $display("TEST RESULT: FAIL");
            $fatal(1, "run stopped by the cycle limit");
        end
    end

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("Mismatch at %0d ns: %s got 0x%0h, expected 0x%0h", $time, name, got, exp);
            $display("TEST RESULT: FAIL");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    // Fibonacci taps of x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [7:0] random_byte();
        logic [7:0] b;
        logic       fb;
        b = '0;
        for (int i = 0; i < 8; i++) begin
            fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
            lfsr_state = {lfsr_state[14:0], fb};
            b = {b[6:0], fb};
        end
        return b;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Scoreboard and table building
    ////////////////////////////////////////////////////////////////////////////
    // Bytes never written count as zero
    function automatic logic [7:0] sb_byte(input int key);
        return sb.exists(key) ? sb[key] : 8'h00;
    endfunction

    // Lane 0 in the low byte
    function automatic logic [31:0] word_from_sb(input int word);
        return {sb_byte(4 * word + 3), sb_byte(4 * word + 2),
                sb_byte(4 * word + 1), sb_byte(4 * word)};
    endfunction

    task automatic add_step(input op_t op, input int addr, input logic [7:0] data,
                            input logic [31:0] exp_val);
        step_t s;
        s.op      = op;
        s.addr    = addr[REG_ADDR_W-1:0];
        s.data    = data;
        s.exp_val = exp_val;
        steps.push_back(s);
    endtask

    task automatic add_write(input int addr);
        logic [7:0] data;
        data = random_byte();
        sb[addr] = data;
        add_step(OP_WRITE, addr, data, {24'h0, data});
    endtask

    task automatic add_pixel(input int idx);
        int         base;
        logic [7:0] hi;
        base = int'(PAL_BASE) + 2 * idx;
        hi = sb_byte(base + 1);
        add_step(OP_PIXEL, idx, 8'h00, {20'h0, hi[3:0], sb_byte(base)});
    endtask

    task automatic build_table();
        // Address 0 shares its low bits with 0x40000 and fetch word 0x8000
        add_write(32'h0);
        for (int k = 0; k < 8; k++) begin
            add_write(32'h40 + k);
        end
        for (int k = 0; k < 4; k++) begin
            add_write(32'h1FFFC + k);
        end
        add_write(32'h12345);
        for (int k = 0; k < 8; k++) begin
            add_step(OP_READ, 32'h40 + k, 8'h00, {24'h0, sb_byte(32'h40 + k)});
        end
        add_step(OP_READ, 32'h12345, 8'h00, {24'h0, sb_byte(32'h12345)});
        add_step(OP_READ, 32'h1FFFE, 8'h00, {24'h0, sb_byte(32'h1FFFE)});
        // Unmapped windows
        add_step(OP_READ, 32'h40000, 8'h00, 32'h0);
        add_step(OP_READ, 32'h7FFFF, 8'h00, 32'h0);
        add_step(OP_FETCH, 32'h0010, 8'h00, word_from_sb(32'h0010));
        add_step(OP_FETCH, 32'h7FFF, 8'h00, word_from_sb(32'h7FFF));
        add_step(OP_FETCH, 32'h8000, 8'h00, 32'h0);
        add_step(OP_FETCH, 32'hFFFF, 8'h00, 32'h0);
        add_step(OP_ARB, 32'h41, 8'h00, {24'h0, sb_byte(32'h41)});
        // Both lanes of palette entry 5
        add_write(int'(PAL_BASE) + 10);
        add_write(int'(PAL_BASE) + 11);
        add_step(OP_READ, int'(PAL_BASE) + 10, 8'h00, {24'h0, sb_byte(int'(PAL_BASE) + 10)});
        add_step(OP_READ, int'(PAL_BASE) + 11, 8'h00, {24'h0, sb_byte(int'(PAL_BASE) + 11)});
        add_pixel(5);
        // All four lanes of sprite entry 9
        for (int k = 0; k < 4; k++) begin
            add_write(int'(SPR_BASE) + 36 + k);
        end
        add_step(OP_SPRITE, 9, 8'h00, word_from_sb((int'(SPR_BASE) + 36) / 4));
        for (int k = 0; k < 4; k++) begin
            add_step(OP_READ, int'(SPR_BASE) + 36 + k, 8'h00,
                     {24'h0, sb_byte(int'(SPR_BASE) + 36 + k)});
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Step execution
    ////////////////////////////////////////////////////////////////////////////
    // Every step starts and ends 1 ns after a rising edge
    task automatic apply_step(input step_t s);
        logic [15:0] word;
        word = s.addr[17:2];
        case (s.op)
            OP_WRITE, OP_READ: begin
                host_req.addr   = s.addr;
                host_req.wrdata = s.data;
                host_req.write  = (s.op == OP_WRITE);
                host_req.strobe = 1'b1;
                @(posedge clk);
                #1;
                host_req.strobe = 1'b0;
                if (s.op == OP_READ) check("host_rddata_o", 32'(host_rddata), s.exp_val);
            end
            OP_FETCH: begin
                fetch_req[0].addr   = s.addr[15:0];
                fetch_req[0].strobe = 1'b1;
                @(posedge clk);
                #1;
                check("fetch_ack_o", 32'(fetch_ack), 32'h1);
                check("fetch_rddata_o", fetch_rddata, s.exp_val);
                fetch_req[0].strobe = 1'b0;
            end
            OP_ARB: begin
                // Host and both fetch ports strobe in the same cycle
                host_req.addr   = s.addr;
                host_req.write  = 1'b0;
                host_req.strobe = 1'b1;
                fetch_req[0]    = {word, 1'b1};
                fetch_req[1]    = {word + 16'd1, 1'b1};
                @(posedge clk);
                #1;
                host_req.strobe = 1'b0;
                check("fetch_ack_o", 32'(fetch_ack), 32'h0);
                check("host_rddata_o", 32'(host_rddata), s.exp_val);
                @(posedge clk);
                #1;
                check("fetch_ack_o", 32'(fetch_ack), 32'h1);
                check("fetch_rddata_o", fetch_rddata, word_from_sb(int'(word)));
                fetch_req[0].strobe = 1'b0;
                @(posedge clk);
                #1;
                check("fetch_ack_o", 32'(fetch_ack), 32'h2);
                check("fetch_rddata_o", fetch_rddata, word_from_sb(int'(word) + 1));
                fetch_req[1].strobe = 1'b0;
            end
            OP_PIXEL: begin
                pixel = s.addr[7:0];
                @(posedge clk);
                #1;
                check("rgb_o", 32'(rgb), s.exp_val);
            end
            default: begin
                sprite_idx = s.addr[7:0];
                @(posedge clk);
                #1;
                check("sprite_attr_o", sprite_attr, s.exp_val);
            end
        endcase
    endtask

    initial begin
        reset      = 1'b1;
        host_req   = '0;
        fetch_req  = '0;
        pixel      = '0;
        sprite_idx = '0;
        build_table();
        timeout_limit = 4 * steps.size() + 100;
        repeat (10) @(posedge clk);
        #1;
        reset = 1'b0;
        check("fetch_ack_o", 32'(fetch_ack), 32'h0);
        check("host_rddata_o", 32'(host_rddata), 32'h0);
        @(posedge clk);
        #1;
        check("fetch_ack_o", 32'(fetch_ack), 32'h0);
        check("host_rddata_o", 32'(host_rddata), 32'h0);
        foreach (steps[i]) apply_step(steps[i]);
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

// File: files.f
logic/video_bus_pkg.sv
logic/main_ram.sv
logic/attr_ram.sv
logic/bus_control.sv
logic/video_bus_top.sv
test/video_bus_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= video_bus_tb
FLAGS     ?= --binary --timing -j 0
OBJ_DIR   ?= obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f files.f

# Pass only if the simulation printed the pass line
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST RESULT: PASS"

clean:
	rm -rf $(OBJ_DIR)
